/* sim/bp_testdata.txt */
# name op(S search, U update, B both) pc target kind(0 cond, 1 jump) taken
# then expected: s1_hit s1_slot s1_target s2_taken s2_target (hex)
reset_miss      S 00001000 00000000 0 0 0 0 00000000 0 00001010
jump_slot2      U 00002008 00003000 1 1 0 0 00000000 0 00000000
jump_slot2      S 00002000 00000000 0 0 1 2 00003000 1 00003000
jump_past_slot  S 0000200c 00000000 0 0 0 0 00000000 0 00002010
two_slots       U 00004004 00005000 1 1 0 0 00000000 0 00000000
two_slots       U 0000400c 00006000 1 1 0 0 00000000 0 00000000
two_slots       S 00004000 00000000 0 0 1 1 00005000 1 00005000
two_slots       S 00004004 00000000 0 0 1 1 00005000 1 00005000
two_slots       S 00004008 00000000 0 0 1 3 00006000 1 00006000
cond_first      U 00007000 00008000 0 1 0 0 00000000 0 00000000
cond_first      S 00007000 00000000 0 0 1 0 00008000 0 00007010
cond_train      U 00007000 00008000 0 1 0 0 00000000 0 00000000
cond_train      U 00007000 00008000 0 1 0 0 00000000 0 00000000
cond_train      U 00007000 00008000 0 1 0 0 00000000 0 00000000
cond_train      U 00007000 00008000 0 1 0 0 00000000 0 00000000
cond_train      U 00007000 00008000 0 1 0 0 00000000 0 00000000
cond_train      U 00007000 00008000 0 1 0 0 00000000 0 00000000
cond_train      U 00007000 00008000 0 1 0 0 00000000 0 00000000
cond_train      S 00007000 00000000 0 0 1 0 00008000 0 00007010
cond_train      U 00007000 00008000 0 1 0 0 00000000 0 00000000
cond_train      S 00007000 00000000 0 0 1 0 00008000 1 00008000
same_cycle_btb  B 00009014 0000a000 1 1 0 0 00000000 0 00009020
same_cycle_btb  S 00009014 00000000 0 0 1 1 0000a000 1 0000a000
same_cycle_pht  B 00007000 00008000 0 0 1 0 00008000 1 00008000
same_cycle_pht  S 00007000 00000000 0 0 1 0 00008000 0 00007010
back_to_back    S 00002000 00000000 0 0 1 2 00003000 1 00003000
back_to_back    S 00004008 00000000 0 0 1 3 00006000 1 00006000
back_to_back    S 00001000 00000000 0 0 0 0 00000000 0 00001010
back_to_back    S 00009014 00000000 0 0 1 1 0000a000 1 0000a000

/* bp_predictor.f */
+incdir+hdl
hdl/bp_pkg.sv
hdl/bp_s0_dispatch.sv
hdl/bp_btb_bank.sv
hdl/bp_hit_select.sv
hdl/bp_gshare.sv
hdl/bp_predictor.sv
sim/bp_predictor_tb.sv

/* Bender.yml */
package:
  name: bp_predictor

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bp_pkg.sv
      - hdl/bp_s0_dispatch.sv
      - hdl/bp_btb_bank.sv
      - hdl/bp_hit_select.sv
      - hdl/bp_gshare.sv
      - hdl/bp_predictor.sv
  - target: test
    files:
      - sim/bp_predictor_tb.sv

/* sim/bp_predictor_tb.sv */
// ------------------------------
// Testbench for the branch predictor front end
// Data-driven searches and updates, s1 and s2 checks
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module bp_predictor_tb;

  localparam int    CLK_PERIOD   = 40;
  localparam int    RESET_CYCLES = 5;
  localparam int    WAIT_LIMIT   = 20;
  localparam string DATA_FILE    = "sim/bp_testdata.txt";

  // One data line with stimulus and expected results
  typedef struct packed {
    bp_pkg::vaddr_t pc;
    bp_pkg::vaddr_t target;
    logic           kind;
    logic           taken;
    logic           hit;
    bp_pkg::slot_t  slot;
    bp_pkg::vaddr_t s1_target;
    logic           s2_taken;
    bp_pkg::vaddr_t s2_target;
  } step_t;

  // A search still waiting for its results
  typedef struct packed {
    int step;
    int cycle;
  } pending_t;

  logic               clk;
  logic               arst_n;
  bp_pkg::fetch_req_t search;
  bp_pkg::br_upd_t    br_upd;
  logic               s1_valid;
  bp_pkg::btb_s1_t    s1_btb;
  bp_pkg::pred_s2_t   s2_pred;

  string    step_name [$];
  string    step_op   [$];
  step_t    steps     [$];
  pending_t s1_queue  [$];
  pending_t s2_queue  [$];

  int cycle       = 0;
  int error_count = 0;
  int pass_count  = 0;
  int fail_count  = 0;

  bp_predictor dut (
    .i_clk      (clk),
    .i_arst_n   (arst_n),
    .i_search   (search),
    .i_br_upd   (br_upd),
    .o_s1_valid (s1_valid),
    .o_s1_btb   (s1_btb),
    .o_s2_pred  (s2_pred)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Cycle count read on the falling edge
  always @(posedge clk) cycle <= cycle + 1;

  // ------------------------------
  // Checking helpers
  // ------------------------------
  task automatic report_mismatch(input string test, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("[FAIL] %s %s: expected %0h, actual %0h", test, field, expected, actual);
    error_count++;
  endtask

  // Kind of the newest earlier update to the same 16-byte block and slot
  function automatic logic last_update_kind(input int idx, input bp_pkg::slot_t slot);
    logic [31:0] blk;
    logic        kind;
    blk  = steps[idx].pc & 32'hffff_fff0;
    kind = 1'b0;
    for (int i = 0; i < idx; i++) begin
      if ((step_op[i] == "U" || step_op[i] == "B") &&
          (steps[i].pc & 32'hffff_fff0) == blk && steps[i].pc[3:2] == slot) begin
        kind = steps[i].kind;
      end
    end
    return kind;
  endfunction

  task automatic check_s1();
    pending_t p;
    step_t    s;
    logic     exp_kind;
    if (s1_queue.size() == 0) begin
      $display("An s1 result appeared at cycle %0d with no search outstanding", cycle);
      error_count++;
    end else begin
      p = s1_queue.pop_front();
      s = steps[p.step];
      exp_kind = last_update_kind(p.step, s.slot);
      if (cycle != p.cycle + 1) begin
        $display("%s: s1 result came %0d cycles after its search, not 1",
                 step_name[p.step], cycle - p.cycle);
        error_count++;
      end
      if (s1_btb.hit !== s.hit)
        report_mismatch(step_name[p.step], "s1 hit", s.hit, s1_btb.hit);
      // Slot, target and kind only mean something on a hit
      if (s.hit && s1_btb.slot !== s.slot)
        report_mismatch(step_name[p.step], "s1 slot", s.slot, s1_btb.slot);
      if (s.hit && s1_btb.target !== s.s1_target)
        report_mismatch(step_name[p.step], "s1 target", s.s1_target, s1_btb.target);
      if (s.hit && s1_btb.kind !== exp_kind)
        report_mismatch(step_name[p.step], "s1 kind", exp_kind, s1_btb.kind);
    end
  endtask

  task automatic check_s2();
    pending_t p;
    step_t    s;
    if (s2_queue.size() == 0) begin
      $display("An s2 prediction appeared at cycle %0d with no search outstanding", cycle);
      error_count++;
    end else begin
      p = s2_queue.pop_front();
      s = steps[p.step];
      if (cycle != p.cycle + 2) begin
        $display("%s: s2 prediction came %0d cycles after its search, not 2",
                 step_name[p.step], cycle - p.cycle);
        error_count++;
      end
      if (s2_pred.taken !== s.s2_taken)
        report_mismatch(step_name[p.step], "s2 taken", s.s2_taken, s2_pred.taken);
      if (s2_pred.target !== s.s2_target)
        report_mismatch(step_name[p.step], "s2 target", s.s2_target, s2_pred.target);
    end
  endtask

  // Outputs sampled mid cycle after they settle
  always @(negedge clk) begin
    if (arst_n) begin
      if (s1_valid) check_s1();
      if (s2_pred.valid) check_s2();
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic load_testdata(output logic ok);
    int             fd;
    int             fields;
    string          line;
    string          name;
    string          op;
    logic [31:0]    f [9];
    step_t          s;
    ok = 1'b0;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the test data file %s", DATA_FILE);
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h", name, op,
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
          if (fields == 11) begin
            s = '{f[0], f[1], f[2][0], f[3][0], f[4][0], f[5][1:0], f[6], f[7][0], f[8]};
            step_name.push_back(name);
            step_op.push_back(op);
            steps.push_back(s);
          end else if (fields > 0) begin
            $display("Skipped a malformed test data line: %s", line);
            error_count++;
          end
        end
      end
      $fclose(fd);
      ok = (steps.size() > 0);
    end
  endtask

  // Drives one line for one cycle from a falling edge
  task automatic issue_step(input int idx);
    step_t    s;
    pending_t p;
    s = steps[idx];
    @(negedge clk);
    search = '0;
    br_upd = '0;
    if (step_op[idx] == "S" || step_op[idx] == "B") begin
      search.valid = 1'b1;
      search.pc    = s.pc;
      p.step       = idx;
      p.cycle      = cycle;
      s1_queue.push_back(p);
      s2_queue.push_back(p);
    end
    if (step_op[idx] == "U" || step_op[idx] == "B") begin
      br_upd.valid  = 1'b1;
      br_upd.pc     = s.pc;
      br_upd.target = s.target;
      br_upd.kind   = bp_pkg::br_kind_e'(s.kind);
      br_upd.taken  = s.taken;
    end
    if (step_op[idx] != "S" && step_op[idx] != "U" && step_op[idx] != "B") begin
      $display("%s: unknown operation %s in the test data", step_name[idx], step_op[idx]);
      error_count++;
    end
  endtask

  // Each output queue drains in its own bounded loop
  task automatic wait_for_results(input string test, output logic timed_out);
    int waited;
    timed_out = 1'b0;
    waited = 0;
    while (s1_queue.size() != 0 && !timed_out) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("%s: timed out waiting for o_s1_valid", test);
        timed_out = 1'b1;
      end
    end
    waited = 0;
    while (s2_queue.size() != 0 && !timed_out) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("%s: timed out waiting for o_s2_pred.valid", test);
        timed_out = 1'b1;
      end
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int    idx;
    int    errors_before;
    string name;
    logic  load_ok;
    logic  timed_out;
    arst_n    = 1'b0;
    search    = '0;
    br_upd    = '0;
    timed_out = 1'b0;
    load_testdata(load_ok);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    idx = 0;
    // Lines sharing a name go out back to back as one test
    while (load_ok && !timed_out && idx < steps.size()) begin
      name = step_name[idx];
      errors_before = error_count;
      while (idx < steps.size() && step_name[idx] == name) begin
        issue_step(idx);
        idx++;
      end
      @(negedge clk);
      search = '0;
      br_upd = '0;
      wait_for_results(name, timed_out);
      if (!timed_out && error_count == errors_before) begin
        pass_count++;
        $display("%s: passed", name);
      end else begin
        fail_count++;
        $display("%s: failed", name);
      end
    end
    $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count,
             error_count);
    if (load_ok && !timed_out && fail_count == 0 && error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/bp_predictor.sv */
// ------------------------------
// Predictor top: dispatch, BTB banks, hit select, gshare
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "bp_defines.svh"

module bp_predictor (
  input  wire                 i_clk,
  input  wire                 i_arst_n,
  input  bp_pkg::fetch_req_t  i_search,
  input  bp_pkg::br_upd_t     i_br_upd,
  output logic                o_s1_valid,
  output bp_pkg::btb_s1_t     o_s1_btb,
  output bp_pkg::pred_s2_t    o_s2_pred
);

  // Dispatch to banks
  bp_pkg::btb_index_t          w_rd_index;
  bp_pkg::btb_tag_t            w_rd_tag;
  bp_pkg::slot_t               w_s1_offset;
  logic [`BP_FETCH_WIDTH-1:0]  w_wr_en;
  bp_pkg::btb_index_t          w_wr_index;
  bp_pkg::btb_entry_t          w_wr_entry;

  // Banks to hit select
  logic [`BP_FETCH_WIDTH-1:0]  w_bank_hit;
  bp_pkg::btb_entry_t          w_bank_entry [`BP_FETCH_WIDTH];

  // ------------------------------
  // s0 dispatch
  // ------------------------------
  bp_s0_dispatch u_dispatch (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_search    (i_search),
    .i_br_upd    (i_br_upd),
    .o_rd_index  (w_rd_index),
    .o_rd_tag    (w_rd_tag),
    .o_s1_valid  (o_s1_valid),
    .o_s1_offset (w_s1_offset),
    .o_wr_en     (w_wr_en),
    .o_wr_index  (w_wr_index),
    .o_wr_entry  (w_wr_entry)
  );

  // ------------------------------
  // BTB, one bank per slot
  // ------------------------------
  for (genvar g = 0; g < `BP_FETCH_WIDTH; g++) begin : g_bank
    bp_btb_bank u_bank (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_rd_index (w_rd_index),
      .i_rd_tag   (w_rd_tag),
      .i_wr_en    (w_wr_en[g]),
      .i_wr_index (w_wr_index),
      .i_wr_entry (w_wr_entry),
      .o_entry    (w_bank_entry[g]),
      .o_hit      (w_bank_hit[g])
    );
  end

  // s1 BTB result
  bp_hit_select u_hit_select (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_s1_valid  (o_s1_valid),
    .i_s1_offset (w_s1_offset),
    .i_hit       (w_bank_hit),
    .i_entries   (w_bank_entry),
    .o_s1_btb    (o_s1_btb)
  );

  // Direction and s2 prediction
  bp_gshare u_gshare (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_search   (i_search),
    .i_br_upd   (i_br_upd),
    .i_s1_valid (o_s1_valid),
    .i_s1_btb   (o_s1_btb),
    .o_s2_pred  (o_s2_pred)
  );

endmodule

`default_nettype wire

/* hdl/bp_gshare.sv */
// ------------------------------
// Gshare: GHR, PHT counters, s2 final prediction
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "bp_defines.svh"

module bp_gshare (
  input  wire                 i_clk,
  input  wire                 i_arst_n,
  input  bp_pkg::fetch_req_t  i_search,
  input  bp_pkg::br_upd_t     i_br_upd,
  input  wire                 i_s1_valid,
  input  bp_pkg::btb_s1_t     i_s1_btb,
  output bp_pkg::pred_s2_t    o_s2_pred
);

  bp_pkg::ghr_t     r_ghr;
  bp_pkg::pht_row_t r_pht [`BP_PHT_ROWS];

  // s0 index, s1 row and block address
  bp_pkg::ghr_t     w_rd_idx;
  bp_pkg::pht_row_t r_s1_row;
  bp_pkg::vaddr_t   r_s1_blk;

  // s1 decision
  logic [1:0]       w_s1_ctr;
  logic             w_s1_taken;
  bp_pkg::vaddr_t   w_s1_target;

  // Update path
  logic             w_upd_cond;
  bp_pkg::ghr_t     w_upd_idx;
  bp_pkg::slot_t    w_upd_slot;
  logic [1:0]       w_upd_ctr;
  logic [1:0]       w_upd_ctr_next;

  // s2 regs
  logic             r_s2_valid;
  logic             r_s2_taken;
  bp_pkg::vaddr_t   r_s2_target;

  // Block number bits above the slot, hashed with history
  function automatic bp_pkg::ghr_t pht_index(bp_pkg::vaddr_t pc, bp_pkg::ghr_t ghr);
    return pc[`BP_BLOCK_LSB +: `BP_GHR_LEN] ^ ghr;
  endfunction

  // ------------------------------
  // s0 PHT read
  // ------------------------------
  assign w_rd_idx = pht_index(i_search.pc, r_ghr);

  always_ff @(posedge i_clk) begin
    if (i_search.valid) begin
      r_s1_row <= r_pht[w_rd_idx];
      r_s1_blk <= i_search.pc & ~bp_pkg::vaddr_t'(`BP_BLOCK_BYTES - 1);
    end
  end

  // ------------------------------
  // s1 direction
  // ------------------------------
  assign w_s1_ctr = r_s1_row[i_s1_btb.slot];

  // Jumps always taken, conditionals by counter MSB
  assign w_s1_taken = i_s1_btb.hit &&
                      ((i_s1_btb.kind == bp_pkg::BR_JUMP) || w_s1_ctr[1]);

  // Fall through to the next fetch block
  assign w_s1_target = w_s1_taken ? i_s1_btb.target :
                       r_s1_blk + bp_pkg::vaddr_t'(`BP_BLOCK_BYTES);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_s2_valid <= 1'b0;
    end else begin
      r_s2_valid <= i_s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s2_taken  <= w_s1_taken;
    r_s2_target <= w_s1_target;
  end

  assign o_s2_pred.valid  = r_s2_valid;
  assign o_s2_pred.taken  = r_s2_taken;
  assign o_s2_pred.target = r_s2_target;

  // ------------------------------
  // Training
  // ------------------------------
  assign w_upd_cond = i_br_upd.valid && (i_br_upd.kind == bp_pkg::BR_COND);
  assign w_upd_idx  = pht_index(i_br_upd.pc, r_ghr);
  assign w_upd_slot = i_br_upd.pc[`BP_OFFSET_W +: `BP_SLOT_W];
  assign w_upd_ctr  = r_pht[w_upd_idx][w_upd_slot];

  // Saturate at 0 and 3
  always_comb begin
    w_upd_ctr_next = w_upd_ctr;
    if (i_br_upd.taken && (w_upd_ctr != 2'd3)) begin
      w_upd_ctr_next = w_upd_ctr + 2'd1;
    end else if (!i_br_upd.taken && (w_upd_ctr != 2'd0)) begin
      w_upd_ctr_next = w_upd_ctr - 2'd1;
    end
  end

  // Counters come out of reset weakly not taken
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `BP_PHT_ROWS; i++) begin
        r_pht[i] <= {`BP_FETCH_WIDTH{2'b01}};
      end
    end else if (w_upd_cond) begin
      r_pht[w_upd_idx][w_upd_slot] <= w_upd_ctr_next;
    end
  end

  // Newest outcome enters at bit 0
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_ghr <= '0;
    end else if (w_upd_cond) begin
      r_ghr <= {r_ghr[`BP_GHR_LEN-2:0], i_br_upd.taken};
    end
  end

  // No s2 result without a search two cycles back
  a_s2_needs_search: assert property (
    @(posedge i_clk) disable iff (!i_arst_n) !i_search.valid |-> ##2 !o_s2_pred.valid
  );

endmodule

`default_nettype wire

/* hdl/bp_hit_select.sv */
// ------------------------------
// s1 pick of the first hitting slot at or after offset
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "bp_defines.svh"

module bp_hit_select (
  input  wire                        i_clk,
  input  wire                        i_arst_n,
  input  wire                        i_s1_valid,
  input  bp_pkg::slot_t              i_s1_offset,
  input  wire [`BP_FETCH_WIDTH-1:0]  i_hit,
  input  bp_pkg::btb_entry_t         i_entries [`BP_FETCH_WIDTH],
  output bp_pkg::btb_s1_t            o_s1_btb
);

  logic [`BP_FETCH_WIDTH-1:0] w_masked;
  bp_pkg::slot_t              w_sel;

  // Slots before the fetch offset are not on the fetch path
  always_comb begin
    for (int i = 0; i < `BP_FETCH_WIDTH; i++) begin
      w_masked[i] = i_s1_valid && i_hit[i] && (i >= int'(i_s1_offset));
    end
  end

  // Walk down from the top so the lowest hit wins
  always_comb begin
    w_sel = '0;
    for (int i = `BP_FETCH_WIDTH - 1; i >= 0; i--) begin
      if (w_masked[i]) begin
        w_sel = bp_pkg::slot_t'(i);
      end
    end
  end

  // ------------------------------
  // s1 result
  // ------------------------------
  assign o_s1_btb.hit  = |w_masked;
  assign o_s1_btb.slot = w_sel;

  // Payload is zero on a miss
  assign o_s1_btb.target = o_s1_btb.hit ? i_entries[w_sel].target : '0;
  assign o_s1_btb.kind   = o_s1_btb.hit ? i_entries[w_sel].kind : bp_pkg::BR_COND;

  // Selected slot must come from a bank hit on a valid entry
  a_sel_is_hit: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
      o_s1_btb.hit |-> i_hit[o_s1_btb.slot] && i_entries[o_s1_btb.slot].valid
  );

endmodule

`default_nettype wire

/* hdl/bp_btb_bank.sv */
// ------------------------------
// One direct-mapped tagged BTB bank, registered read
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "bp_defines.svh"

module bp_btb_bank (
  input  wire                 i_clk,
  input  wire                 i_arst_n,
  input  bp_pkg::btb_index_t  i_rd_index,
  input  bp_pkg::btb_tag_t    i_rd_tag,
  input  wire                 i_wr_en,
  input  bp_pkg::btb_index_t  i_wr_index,
  input  bp_pkg::btb_entry_t  i_wr_entry,
  output bp_pkg::btb_entry_t  o_entry,
  output logic                o_hit
);

  // Valid bits, cleared on reset
  logic [`BP_BTB_ENTRIES-1:0] r_valid;

  // Payload arrays
  bp_pkg::btb_tag_t  r_tag    [`BP_BTB_ENTRIES];
  bp_pkg::vaddr_t    r_target [`BP_BTB_ENTRIES];
  bp_pkg::br_kind_e  r_kind   [`BP_BTB_ENTRIES];

  // s1 read data and search tag
  logic              r_rd_valid;
  bp_pkg::btb_tag_t  r_rd_tag;
  bp_pkg::btb_tag_t  r_rd_entry_tag;
  bp_pkg::vaddr_t    r_rd_target;
  bp_pkg::br_kind_e  r_rd_kind;

  // ------------------------------
  // Write port
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_valid <= '0;
    end else if (i_wr_en) begin
      r_valid[i_wr_index] <= i_wr_entry.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      r_tag[i_wr_index]    <= i_wr_entry.tag;
      r_target[i_wr_index] <= i_wr_entry.target;
      r_kind[i_wr_index]   <= i_wr_entry.kind;
    end
  end

  // ------------------------------
  // Read port
  // ------------------------------
  // Array sampled at s0 edge, so a same-cycle write is not seen
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_rd_valid <= 1'b0;
    end else begin
      r_rd_valid <= r_valid[i_rd_index];
    end
  end

  always_ff @(posedge i_clk) begin
    r_rd_tag       <= i_rd_tag;
    r_rd_entry_tag <= r_tag[i_rd_index];
    r_rd_target    <= r_target[i_rd_index];
    r_rd_kind      <= r_kind[i_rd_index];
  end

  assign o_entry.valid  = r_rd_valid;
  assign o_entry.tag    = r_rd_entry_tag;
  assign o_entry.target = r_rd_target;
  assign o_entry.kind   = r_rd_kind;

  // Tag compare at s1
  assign o_hit = r_rd_valid && (r_rd_entry_tag == r_rd_tag);

  a_wr_index_known: assert property (
    @(posedge i_clk) disable iff (!i_arst_n) i_wr_en |-> !$isunknown(i_wr_index)
  );

endmodule

`default_nettype wire

/* hdl/bp_s0_dispatch.sv */
// ------------------------------
// s0 stage: search split, s1 regs, update decode
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "bp_defines.svh"

module bp_s0_dispatch (
  input  wire                     i_clk,
  input  wire                     i_arst_n,
  input  bp_pkg::fetch_req_t      i_search,
  input  bp_pkg::br_upd_t         i_br_upd,
  output bp_pkg::btb_index_t      o_rd_index,
  output bp_pkg::btb_tag_t        o_rd_tag,
  output logic                    o_s1_valid,
  output bp_pkg::slot_t           o_s1_offset,
  output logic [`BP_FETCH_WIDTH-1:0] o_wr_en,
  output bp_pkg::btb_index_t      o_wr_index,
  output bp_pkg::btb_entry_t      o_wr_entry
);

  bp_pkg::slot_t w_upd_slot;

  // Same search index and tag go to every bank
  assign o_rd_index = i_search.pc[`BP_BLOCK_LSB +: `BP_INDEX_W];
  assign o_rd_tag   = i_search.pc[`BP_VADDR_W-1 -: `BP_TAG_W];

  // Search valid into s1
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_s1_valid <= 1'b0;
    end else begin
      o_s1_valid <= i_search.valid;
    end
  end

  // Fetch slot offset into s1
  always_ff @(posedge i_clk) begin
    o_s1_offset <= i_search.pc[`BP_OFFSET_W +: `BP_SLOT_W];
  end

  // ------------------------------
  // Update decode
  // ------------------------------
  assign w_upd_slot = i_br_upd.pc[`BP_OFFSET_W +: `BP_SLOT_W];

  // Update slot picks its bank
  always_comb begin
    o_wr_en = '0;
    if (i_br_upd.valid) begin
      o_wr_en[w_upd_slot] = 1'b1;
    end
  end

  assign o_wr_index        = i_br_upd.pc[`BP_BLOCK_LSB +: `BP_INDEX_W];
  assign o_wr_entry.valid  = 1'b1;
  assign o_wr_entry.tag    = i_br_upd.pc[`BP_VADDR_W-1 -: `BP_TAG_W];
  assign o_wr_entry.target = i_br_upd.target;
  assign o_wr_entry.kind   = i_br_upd.kind;

  // A valid update writes exactly one bank
  a_wr_en_onehot: assert property (
    @(posedge i_clk) disable iff (!i_arst_n) i_br_upd.valid |-> $onehot(o_wr_en)
  );

endmodule

`default_nettype wire

/* hdl/bp_pkg.sv */
// ------------------------------
// Shared predictor types: requests, BTB entries, results
// ------------------------------
`default_nettype none

`include "bp_defines.svh"

package bp_pkg;

  // Address pieces
  typedef logic [`BP_VADDR_W-1:0] vaddr_t;
  typedef logic [`BP_SLOT_W-1:0]  slot_t;
  typedef logic [`BP_INDEX_W-1:0] btb_index_t;
  typedef logic [`BP_TAG_W-1:0]   btb_tag_t;
  typedef logic [`BP_GHR_LEN-1:0] ghr_t;

  // Branch kind, one bit
  typedef enum logic {
    BR_COND = 1'b0,
    BR_JUMP = 1'b1
  } br_kind_e;

  // Fetch search strobe
  typedef struct packed {
    logic   valid;
    vaddr_t pc;
  } fetch_req_t;

  // Resolved branch from the back end
  typedef struct packed {
    logic     valid;
    vaddr_t   pc;
    vaddr_t   target;
    br_kind_e kind;
    logic     taken;
  } br_upd_t;

  typedef struct packed {
    logic     valid;
    btb_tag_t tag;
    vaddr_t   target;
    br_kind_e kind;
  } btb_entry_t;

  // s1 BTB lookup result
  typedef struct packed {
    logic     hit;
    slot_t    slot;
    vaddr_t   target;
    br_kind_e kind;
  } btb_s1_t;

  // s2 final prediction
  typedef struct packed {
    logic   valid;
    logic   taken;
    vaddr_t target;
  } pred_s2_t;

  // One 2-bit counter per slot
  typedef logic [`BP_FETCH_WIDTH-1:0][1:0] pht_row_t;

endpackage

`default_nettype wire

/* hdl/bp_defines.svh */
// ------------------------------
// Predictor sizing macros and derived PC field widths
// ------------------------------
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// Fetch block geometry
`define BP_FETCH_WIDTH 4
`define BP_INSN_BYTES  4
`define BP_BLOCK_BYTES (`BP_FETCH_WIDTH * `BP_INSN_BYTES)

// Table sizes
`define BP_BTB_ENTRIES 16
`define BP_GHR_LEN     8
`define BP_PHT_ROWS    (1 << `BP_GHR_LEN)

// Virtual address and its fields, low to high
// offset | slot | bank index | tag
`define BP_VADDR_W   32
`define BP_OFFSET_W  $clog2(`BP_INSN_BYTES)
`define BP_SLOT_W    $clog2(`BP_FETCH_WIDTH)
`define BP_INDEX_W   $clog2(`BP_BTB_ENTRIES)
`define BP_BLOCK_LSB (`BP_OFFSET_W + `BP_SLOT_W)
`define BP_TAG_W     (`BP_VADDR_W - `BP_INDEX_W - `BP_BLOCK_LSB)

`endif
